/* Bender.yml */
package:
  name: lsu_mem_region

sources:
  - verilog/region_pkg.sv
  - verilog/data_ram.sv
  - verilog/ram_arbiter.sv
  - verilog/lsu_demux.sv
  - verilog/lsu_mem_region.sv
  - target: test
    files:
      - tests/region_checker.sv
      - tests/tb_lsu_mem_region.sv

/* tests/region_checker.sv */
// reference model of the data RAM; watches lsu_mem_region, checks every response and counts errors
module region_checker #(
  parameter int unsigned RAM_SIZE = 262144
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        lsu_req_i,
  input  logic [31:0] lsu_addr_i,
  input  logic        lsu_we_i,
  input  logic [3:0]  lsu_be_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic        lsu_gnt_i,
  input  logic        lsu_rvalid_i,
  input  logic [31:0] lsu_rdata_i,
  input  logic        ext_req_i,
  input  logic [31:0] ext_addr_i,
  input  logic        ext_we_i,
  input  logic [3:0]  ext_be_i,
  input  logic [31:0] ext_wdata_i,
  input  logic        ext_gnt_i,
  input  logic        ext_rvalid_i,
  input  logic        bus_req_i,
  input  logic [31:0] bus_addr_i,
  input  logic        bus_we_i,
  input  logic [7:0]  bus_be_i,
  input  logic [63:0] bus_wdata_i,
  input  logic [63:0] bus_rdata_i,
  output int          error_count_o,
  output int          check_count_o
);

  logic [7:0]  model [RAM_SIZE];
  logic        lsu_pending;
  logic        lsu_is_read;
  logic [31:0] lsu_expect;
  logic        local_due;
  logic        bus_pending;
  logic [63:0] bus_expect;
  int unsigned base;
  int          errors = 0;
  int          checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  // page 0x001 in the upper 12 bits is the local RAM
  function automatic logic targets_ram(input logic [31:0] addr);
    return addr[31:20] == 12'h001;
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      report($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      lsu_pending = 1'b0;
      bus_pending = 1'b0;
      local_due   = 1'b0;
    end else begin
      // local answers one cycle after the grant, external ones pass straight through
      if (lsu_rvalid_i !== (local_due || ext_rvalid_i)) begin
        report($sformatf("lsu_rvalid is %b, expected %b", lsu_rvalid_i,
                         local_due || ext_rvalid_i));
      end
      local_due = 1'b0;

      // responses to accesses of earlier cycles
      if (lsu_rvalid_i) begin
        if (!lsu_pending) begin
          report("lsu rvalid seen with no request outstanding");
        end else if (lsu_is_read) begin
          compare("lsu rdata", {32'h0, lsu_rdata_i}, {32'h0, lsu_expect});
        end
        lsu_pending = 1'b0;
      end
      if (bus_pending) begin
        compare("bus rdata", bus_rdata_i, bus_expect);
        bus_pending = 1'b0;
      end

      if (ext_req_i !== (lsu_req_i && !targets_ram(lsu_addr_i))) begin
        report($sformatf("ext_req is %b for lsu address %h", ext_req_i, lsu_addr_i));
      end
      if (bus_req_i && lsu_gnt_i) begin
        report("lsu grant given while the wide bus holds the RAM");
      end
      if (lsu_req_i && targets_ram(lsu_addr_i) && !bus_req_i && !lsu_gnt_i) begin
        report("local lsu request not granted while the RAM is free");
      end
      if (lsu_req_i && !targets_ram(lsu_addr_i) && lsu_gnt_i !== ext_gnt_i) begin
        report($sformatf("lsu_gnt is %b, expected %b from ext_gnt", lsu_gnt_i, ext_gnt_i));
      end

      // wide bus takes the RAM in its own cycle
      if (bus_req_i) begin
        base = (bus_addr_i % RAM_SIZE) & ~32'h7;
        for (int i = 0; i < 8; i++) begin
          if (bus_we_i && bus_be_i[i]) begin
            model[base + i] = bus_wdata_i[8*i +: 8];
          end
          bus_expect[8*i +: 8] = model[base + i];
        end
        bus_pending = !bus_we_i;
      end

      if (lsu_req_i && lsu_gnt_i) begin
        if (lsu_pending) begin
          report("lsu request accepted before the previous response");
        end
        lsu_pending = 1'b1;
        lsu_is_read = !lsu_we_i;
        if (targets_ram(lsu_addr_i)) begin
          local_due = 1'b1;
          base = (lsu_addr_i % RAM_SIZE) & ~32'h3;
          for (int i = 0; i < 4; i++) begin
            if (lsu_we_i && lsu_be_i[i]) begin
              model[base + i] = lsu_wdata_i[8*i +: 8];
            end
            lsu_expect[8*i +: 8] = model[base + i];
          end
        end else begin
          if (ext_addr_i !== lsu_addr_i) begin
            report($sformatf("ext_addr is %h, expected %h", ext_addr_i, lsu_addr_i));
          end
          if (ext_we_i !== lsu_we_i || ext_be_i !== lsu_be_i) begin
            report($sformatf("ext_we/ext_be are %b/%h, expected %b/%h", ext_we_i, ext_be_i,
                             lsu_we_i, lsu_be_i));
          end
          if (ext_wdata_i !== lsu_wdata_i) begin
            report($sformatf("ext_wdata is %h, expected %h", ext_wdata_i, lsu_wdata_i));
          end
          // external responder answers reads with a scrambled address
          lsu_expect = lsu_addr_i ^ 32'hA5A5A5A5;
        end
      end
    end
  end

endmodule

/* tests/tb_lsu_mem_region.sv */
// testbench for lsu_mem_region; runs the stimulus table against the DUT and an external responder
module tb_lsu_mem_region;

  localparam int unsigned RAM_SIZE       = 262144;
  localparam int          N_STEPS        = 20;
  localparam int          TIMEOUT_CYCLES = N_STEPS * 8 + 50;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        lsu_req;
  logic [31:0] lsu_addr;
  logic        lsu_we;
  logic [3:0]  lsu_be;
  logic [31:0] lsu_wdata;
  logic        lsu_gnt;
  logic        lsu_rvalid;
  logic [31:0] lsu_rdata;
  logic        ext_req;
  logic [31:0] ext_addr;
  logic        ext_we;
  logic [3:0]  ext_be;
  logic [31:0] ext_wdata;
  logic        ext_gnt;
  logic        ext_rvalid;
  logic [31:0] ext_rdata;
  logic        bus_req;
  logic [31:0] bus_addr;
  logic        bus_we;
  logic [7:0]  bus_be;
  logic [63:0] bus_wdata;
  logic [63:0] bus_rdata;
  int          error_count;
  int          check_count;
  int          cycle_count;
  int unsigned seed_val;

  // stimulus table with one column per field
  logic        step_bus     [N_STEPS];
  logic        step_we      [N_STEPS];
  logic [31:0] step_addr    [N_STEPS];
  logic [7:0]  step_be      [N_STEPS];
  logic [63:0] step_data    [N_STEPS];
  logic        step_overlap [N_STEPS];
  int          n_filled = 0;

  always #2 clk = ~clk;

  lsu_mem_region #(.RAM_SIZE(RAM_SIZE)) uut (
    .clk(clk), .rst_n(rst_n),
    .lsu_req_i(lsu_req), .lsu_addr_i(lsu_addr), .lsu_we_i(lsu_we), .lsu_be_i(lsu_be),
    .lsu_wdata_i(lsu_wdata), .lsu_gnt_o(lsu_gnt), .lsu_rvalid_o(lsu_rvalid),
    .lsu_rdata_o(lsu_rdata),
    .ext_req_o(ext_req), .ext_addr_o(ext_addr), .ext_we_o(ext_we), .ext_be_o(ext_be),
    .ext_wdata_o(ext_wdata), .ext_gnt_i(ext_gnt), .ext_rvalid_i(ext_rvalid),
    .ext_rdata_i(ext_rdata),
    .bus_req_i(bus_req), .bus_addr_i(bus_addr), .bus_we_i(bus_we), .bus_be_i(bus_be),
    .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata)
  );

  region_checker #(.RAM_SIZE(RAM_SIZE)) u_checker (
    .clk(clk), .rst_n(rst_n),
    .lsu_req_i(lsu_req), .lsu_addr_i(lsu_addr), .lsu_we_i(lsu_we), .lsu_be_i(lsu_be),
    .lsu_wdata_i(lsu_wdata), .lsu_gnt_i(lsu_gnt), .lsu_rvalid_i(lsu_rvalid),
    .lsu_rdata_i(lsu_rdata), .ext_req_i(ext_req), .ext_addr_i(ext_addr),
    .ext_we_i(ext_we), .ext_be_i(ext_be), .ext_wdata_i(ext_wdata),
    .ext_gnt_i(ext_gnt), .ext_rvalid_i(ext_rvalid),
    .bus_req_i(bus_req), .bus_addr_i(bus_addr), .bus_we_i(bus_we), .bus_be_i(bus_be),
    .bus_wdata_i(bus_wdata), .bus_rdata_i(bus_rdata),
    .error_count_o(error_count), .check_count_o(check_count)
  );

  task automatic add_step(input logic is_bus, input logic we, input logic [31:0] addr,
                          input logic [7:0] be, input logic [63:0] data, input logic overlap);
    step_bus[n_filled]     = is_bus;
    step_we[n_filled]      = we;
    step_addr[n_filled]    = addr;
    step_be[n_filled]      = be;
    step_data[n_filled]    = data;
    step_overlap[n_filled] = overlap;
    n_filled++;
  endtask

  task automatic run_lsu(input int k);
    lsu_req   = 1'b1;
    lsu_addr  = step_addr[k];
    lsu_we    = step_we[k];
    lsu_be    = step_be[k][3:0];
    lsu_wdata = step_data[k][31:0];
    // wide bus reads the same word for two cycles and blocks the grant
    if (step_overlap[k]) begin
      bus_req = 1'b1;
      bus_addr = step_addr[k];
      bus_we = 1'b0;
      bus_be = 8'hFF;
      repeat (2) @(posedge clk);
      #1 bus_req = 1'b0;
    end
    @(posedge clk);
    while (!lsu_gnt) @(posedge clk);
    #1 lsu_req = 1'b0;
    @(posedge clk);
    while (!lsu_rvalid) @(posedge clk);
    #1;
  endtask

  task automatic run_bus(input int k);
    bus_req   = 1'b1;
    bus_addr  = step_addr[k];
    bus_we    = step_we[k];
    bus_be    = step_be[k];
    bus_wdata = step_data[k];
    @(posedge clk);
    #1 bus_req = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // external slave grants after 0 to 2 cycles and answers one cycle later
  initial begin
    int unsigned wait_cycles;
    logic [31:0] req_addr;
    logic        req_read;
    seed_val = $urandom(1);
    forever begin
      @(posedge clk);
      if (ext_req) begin
        wait_cycles = $urandom % 3;
        repeat (wait_cycles) @(posedge clk);
        #1 ext_gnt = 1'b1;
        @(posedge clk);
        req_addr = ext_addr;
        req_read = !ext_we;
        #1 ext_gnt = 1'b0;
        ext_rvalid = 1'b1;
        ext_rdata = req_read ? (req_addr ^ 32'hA5A5A5A5) : 32'h0;
        @(posedge clk);
        #1 ext_rvalid = 1'b0;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("simulation timed out after %0d cycles, %0d errors so far", cycle_count,
             error_count);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    {lsu_req, lsu_we, lsu_addr, lsu_be, lsu_wdata} = '0;
    {bus_req, bus_we, bus_addr, bus_be, bus_wdata} = '0;
    {ext_gnt, ext_rvalid, ext_rdata} = '0;

    // partial byte enables merge into earlier words
    add_step(0, 1, 32'h0010_0010, 8'h0F, 64'h1122_3344, 0);
    add_step(0, 1, 32'h0010_0010, 8'h05, 64'hAABB_CCDD, 0);
    add_step(0, 1, 32'h0010_0014, 8'h0F, 64'h0BAD_F00D, 0);
    add_step(0, 1, 32'h0010_0014, 8'h0C, 64'h5566_7788, 0);
    add_step(0, 0, 32'h0010_0010, 8'h0F, 64'h0, 0);
    add_step(0, 0, 32'h0010_0014, 8'h0F, 64'h0, 0);
    // wide write seen from both lanes
    add_step(1, 1, 32'h0010_0040, 8'hFF, 64'h8877_6655_4433_2211, 0);
    add_step(0, 0, 32'h0010_0040, 8'h0F, 64'h0, 0);
    add_step(0, 0, 32'h0010_0044, 8'h0F, 64'h0, 0);
    add_step(0, 1, 32'h0010_0048, 8'h0F, 64'hDEAD_BEEF, 0);
    add_step(0, 1, 32'h0010_004C, 8'h0F, 64'hCAFE_F00D, 0);
    add_step(1, 0, 32'h0010_0048, 8'hFF, 64'h0, 0);
    // collisions with the wide bus
    add_step(0, 0, 32'h0010_0010, 8'h0F, 64'h0, 1);
    add_step(0, 1, 32'h0010_0044, 8'h08, 64'h9900_0000, 1);
    add_step(0, 0, 32'h0010_0044, 8'h0F, 64'h0, 0);
    // external page leaves the local words as they are
    add_step(0, 0, 32'h2000_0010, 8'h0F, 64'h0, 0);
    add_step(0, 1, 32'h2000_0040, 8'h0F, 64'h1234_5678, 0);
    add_step(0, 0, 32'h0000_0044, 8'h0F, 64'h0, 0);
    add_step(0, 0, 32'h0010_0040, 8'h0F, 64'h0, 0);
    add_step(1, 0, 32'h0010_0040, 8'hFF, 64'h0, 0);

    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    // idle after reset with rvalid and ext_req low
    repeat (2) @(posedge clk);
    #1;

    for (int k = 0; k < n_filled; k++) begin
      if (step_bus[k]) begin
        run_bus(k);
      end else begin
        run_lsu(k);
      end
    end
    repeat (3) @(posedge clk);

    $display("run finished: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/region_pkg.sv
verilog/data_ram.sv
verilog/ram_arbiter.sv
verilog/lsu_demux.sv
verilog/lsu_mem_region.sv
tests/region_checker.sv
tests/tb_lsu_mem_region.sv

/* verilog/data_ram.sv */
// single-port data RAM with byte enables, read data one cycle after en; RAM_SIZE in bytes
module data_ram #(
  parameter int unsigned  RAM_SIZE = 262144,
  localparam int unsigned ADDR_W   = $clog2(RAM_SIZE) - region_pkg::BUS_BYTE_BITS
) (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic [ADDR_W-1:0]     addr_i,
  input  logic                  we_i,
  input  region_pkg::bus_be_t   be_i,
  input  region_pkg::bus_data_t wdata_i,
  output region_pkg::bus_data_t rdata_o
);

  import region_pkg::*;

  localparam int unsigned NUM_WORDS = RAM_SIZE >> BUS_BYTE_BITS;
  localparam int unsigned NUM_BYTES = $bits(bus_be_t);

  bus_data_t mem [NUM_WORDS];

  // one port, so a write cycle leaves rdata_o holding the last read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int i = 0; i < NUM_BYTES; i++) begin
          if (be_i[i]) begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* verilog/lsu_demux.sv */
// load/store address decoder, steers req to local RAM or external port and muxes responses back
module lsu_demux (
  input  logic                  clk,
  input  logic                  rst_n,

  // load/store port
  input  logic                  lsu_req_i,
  input  region_pkg::lsu_addr_t lsu_addr_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output region_pkg::lsu_data_t lsu_rdata_o,

  // external port strobes
  output logic                  ext_req_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  region_pkg::lsu_data_t ext_rdata_i,

  // local RAM side through the arbiter
  output logic                  ram_req_o,
  input  logic                  ram_gnt_i,
  input  logic                  ram_rvalid_i,
  input  region_pkg::lsu_data_t ram_rdata_i
);

  import region_pkg::*;

  localparam int unsigned ADDR_W = $bits(lsu_addr_t);

  typedef enum logic {
    RESP_RAM,
    RESP_EXT
  } resp_src_e;

  resp_src_e resp_q;
  resp_src_e resp_d;
  logic      is_local;

  assign is_local  = (lsu_addr_i[ADDR_W-1 -: LOCAL_PAGE_BITS] == LOCAL_PAGE);
  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // grant comes from the side the request went to
  // and the next response is expected from there too
  always_comb begin
    resp_d    = resp_q;
    lsu_gnt_o = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      resp_d    = RESP_EXT;
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      resp_d    = RESP_RAM;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q <= RESP_RAM;
    end else begin
      resp_q <= resp_d;
    end
  end

  // one outstanding access, so at most one source answers
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (resp_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;

  // local and external responses never overlap
  assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_rvalid_i && ext_rvalid_i));

endmodule

/* verilog/lsu_mem_region.sv */
// top of the memory region: load/store demux, wide-bus arbiter and the shared data RAM
module lsu_mem_region #(
  parameter int unsigned RAM_SIZE = 262144
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // load/store port
  input  logic                  lsu_req_i,
  input  region_pkg::lsu_addr_t lsu_addr_i,
  input  logic                  lsu_we_i,
  input  region_pkg::lsu_be_t   lsu_be_i,
  input  region_pkg::lsu_data_t lsu_wdata_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output region_pkg::lsu_data_t lsu_rdata_o,

  // external port
  output logic                  ext_req_o,
  output region_pkg::lsu_addr_t ext_addr_o,
  output logic                  ext_we_o,
  output region_pkg::lsu_be_t   ext_be_o,
  output region_pkg::lsu_data_t ext_wdata_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  region_pkg::lsu_data_t ext_rdata_i,

  // wide bus port
  input  logic                  bus_req_i,
  input  region_pkg::lsu_addr_t bus_addr_i,
  input  logic                  bus_we_i,
  input  region_pkg::bus_be_t   bus_be_i,
  input  region_pkg::bus_data_t bus_wdata_i,
  output region_pkg::bus_data_t bus_rdata_o
);

  import region_pkg::*;

  localparam int unsigned RAM_ADDR_W = $clog2(RAM_SIZE) - BUS_BYTE_BITS;

  // demux to arbiter
  logic      ram_req;
  logic      ram_gnt;
  logic      ram_rvalid;
  lsu_data_t ram_rdata;

  // arbiter to RAM
  logic                  mem_en;
  logic [RAM_ADDR_W-1:0] mem_addr;
  logic                  mem_we;
  bus_be_t               mem_be;
  bus_data_t             mem_wdata;
  bus_data_t             mem_rdata;

  // payload fans out to both sides, only req is steered
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  lsu_demux u_lsu_demux (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ext_req_o    (ext_req_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .ram_req_o    (ram_req),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata)
  );

  ram_arbiter #(
    .RAM_SIZE (RAM_SIZE)
  ) u_ram_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_we_i     (bus_we_i),
    .bus_be_i     (bus_be_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rdata_o  (bus_rdata_o),
    .lsu_req_i    (ram_req),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (ram_gnt),
    .lsu_rvalid_o (ram_rvalid),
    .lsu_rdata_o  (ram_rdata),
    .ram_en_o     (mem_en),
    .ram_addr_o   (mem_addr),
    .ram_we_o     (mem_we),
    .ram_be_o     (mem_be),
    .ram_wdata_o  (mem_wdata),
    .ram_rdata_i  (mem_rdata)
  );

  data_ram #(
    .RAM_SIZE (RAM_SIZE)
  ) u_data_ram (
    .clk     (clk),
    .en_i    (mem_en),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

/* verilog/ram_arbiter.sv */
// fixed-priority sharing of the data RAM between the wide bus and the 32-bit load/store port
module ram_arbiter #(
  parameter int unsigned  RAM_SIZE = 262144,
  localparam int unsigned ADDR_W   = $clog2(RAM_SIZE) - region_pkg::BUS_BYTE_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // wide bus port, always served in its cycle
  input  logic                  bus_req_i,
  input  region_pkg::lsu_addr_t bus_addr_i,
  input  logic                  bus_we_i,
  input  region_pkg::bus_be_t   bus_be_i,
  input  region_pkg::bus_data_t bus_wdata_i,
  output region_pkg::bus_data_t bus_rdata_o,

  // load/store port from the demux
  input  logic                  lsu_req_i,
  input  region_pkg::lsu_addr_t lsu_addr_i,
  input  logic                  lsu_we_i,
  input  region_pkg::lsu_be_t   lsu_be_i,
  input  region_pkg::lsu_data_t lsu_wdata_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output region_pkg::lsu_data_t lsu_rdata_o,

  // RAM side
  output logic                  ram_en_o,
  output logic [ADDR_W-1:0]     ram_addr_o,
  output logic                  ram_we_o,
  output region_pkg::bus_be_t   ram_be_o,
  output region_pkg::bus_data_t ram_wdata_o,
  input  region_pkg::bus_data_t ram_rdata_i
);

  import region_pkg::*;

  localparam int unsigned LSU_W    = $bits(lsu_data_t);
  localparam int unsigned BUS_W    = $bits(bus_data_t);
  // address bit that picks the 32-bit half of a wide word
  localparam int unsigned LANE_BIT = $clog2($bits(lsu_be_t));

  logic    lsu_lane;
  logic    lane_q;
  logic    rvalid_q;
  bus_be_t lsu_be_wide;

  assign lsu_lane = lsu_addr_i[LANE_BIT];

  // the bus port wins every conflict
  assign lsu_gnt_o = lsu_req_i & ~bus_req_i;

  // move the 4 byte enables into the addressed half
  assign lsu_be_wide = lsu_lane ? {lsu_be_i, lsu_be_t'(0)} : {lsu_be_t'(0), lsu_be_i};

  always_comb begin
    ram_en_o = bus_req_i | lsu_req_i;
    if (bus_req_i) begin
      ram_addr_o  = bus_addr_i[BUS_BYTE_BITS +: ADDR_W];
      ram_we_o    = bus_we_i;
      ram_be_o    = bus_be_i;
      ram_wdata_o = bus_wdata_i;
    end else begin
      ram_addr_o  = lsu_addr_i[BUS_BYTE_BITS +: ADDR_W];
      ram_we_o    = lsu_we_i;
      ram_be_o    = lsu_be_wide;
      // same word in both halves, be picks the lane
      ram_wdata_o = {lsu_wdata_i, lsu_wdata_i};
    end
  end

  // response of a granted load/store access one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= lsu_gnt_o;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_gnt_o) begin
      lane_q <= lsu_lane;
    end
  end

  assign lsu_rvalid_o = rvalid_q;
  assign lsu_rdata_o  = lane_q ? ram_rdata_i[BUS_W-1 -: LSU_W] : ram_rdata_i[LSU_W-1:0];
  assign bus_rdata_o  = ram_rdata_i;

  // a bus cycle blocks the load/store grant and so its response in the next cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i |-> !lsu_gnt_o ##1 !lsu_rvalid_o);

endmodule

/* verilog/region_pkg.sv */
// shared vector types and address map of the load/store memory region, imported by all RTL
package region_pkg;

  // load/store side, one 32-bit word per access
  typedef logic [31:0] lsu_addr_t;
  typedef logic [31:0] lsu_data_t;
  typedef logic [3:0]  lsu_be_t;

  // wide bus and data RAM word
  typedef logic [63:0] bus_data_t;
  typedef logic [7:0]  bus_be_t;

  // upper address bits compared by the decoder
  localparam int unsigned LOCAL_PAGE_BITS = 12;

  // page 0x001 maps onto the local data RAM
  // everything else goes to the external port
  localparam logic [LOCAL_PAGE_BITS-1:0] LOCAL_PAGE = 12'h001;

  // byte offset inside one wide word
  localparam int unsigned BUS_BYTE_BITS = 3;

endpackage
